// ==== verilog/ooo_pkg.sv ====
// Back-end slice shared definitions
`default_nettype none

package ooo_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  localparam int SLOTS     = 2;   // Instructions per cycle
  localparam int DATA_W    = 64;
  localparam int IR_W      = 32;
  localparam int ARF_IDX_W = 5;
  localparam int PRF_IDX_W = 6;
  localparam int PRF_SZ    = 64;
  localparam int COUNT_W   = 4;   // Width of the completed count

  // Register file read ports, operands first then retire
  localparam int OPND_PORTS  = 2 * SLOTS;
  localparam int RF_RD_PORTS = OPND_PORTS + SLOTS;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [IR_W-1:0]      inst_t;
  typedef logic [PRF_IDX_W-1:0] preg_idx_t;
  typedef logic [ARF_IDX_W-1:0] areg_idx_t;
  typedef logic [3:0]           err_status_t;

  //////////////////////////////////////////////////
  // Special values
  //////////////////////////////////////////////////
  localparam preg_idx_t ZERO_PRF = 6'd63;   // Always reads zero

  localparam inst_t HALT_INST = 32'h0000_0555;
  localparam inst_t NOOP_INST = 32'h47ff_041f;   // Loaded on reset and flush

  // Error status codes
  localparam err_status_t NO_ERROR       = 4'h0;
  localparam err_status_t HALTED_ON_HALT = 4'h1;

endpackage

`default_nettype wire

// ==== verilog/phys_regfile.sv ====
// Physical register file
`default_nettype none

module phys_regfile
  import ooo_pkg::*;
(
  input  wire              clock,
  input  wire              arst_n,

  // CDB write ports
  input  wire              wr_en   [SLOTS],
  input  wire  preg_idx_t  wr_idx  [SLOTS],
  input  wire  word_t      wr_data [SLOTS],

  // Operand and retire read ports
  input  wire  preg_idx_t  rd_idx  [RF_RD_PORTS],
  output word_t            rd_data [RF_RD_PORTS]
);

  word_t regs [PRF_SZ];

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Both CDB ports write at the edge, zero register never written
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int r = 0; r < PRF_SZ; r++)
      begin
        regs[r] <= '0;
      end
    end
    else
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        if (wr_en[s] && (wr_idx[s] != ZERO_PRF))
        begin
          regs[wr_idx[s]] <= wr_data[s];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int p = 0; p < RF_RD_PORTS; p++)
    begin
      if (rd_idx[p] == ZERO_PRF)
      begin
        rd_data[p] = '0;             // Hardwired zero
      end
      else
      begin
        rd_data[p] = regs[rd_idx[p]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dispatch_buffer.sv ====
// Decode to dispatch pair register
`default_nettype none

module dispatch_buffer
  import ooo_pkg::*;
(
  input  wire              clock,
  input  wire              arst_n,
  input  wire              flush,         // Mispredict

  // Dispatch target levels
  input  wire              full,
  input  wire              almost_full,

  // Decode side
  input  wire              in_valid  [SLOTS],
  input  wire  preg_idx_t  in_pdest  [SLOTS],
  input  wire  preg_idx_t  in_prega  [SLOTS],
  input  wire  preg_idx_t  in_pregb  [SLOTS],
  input  wire  inst_t      in_ir     [SLOTS],
  input  wire  word_t      in_npc    [SLOTS],
  output logic             in_ready,

  // Buffered pair
  output preg_idx_t        slot_pdest    [SLOTS],
  output preg_idx_t        slot_prega    [SLOTS],
  output preg_idx_t        slot_pregb    [SLOTS],
  output inst_t            slot_ir       [SLOTS],
  output word_t            slot_npc      [SLOTS],
  output logic             dispatch_fire [SLOTS]
);

  logic [SLOTS-1:0] stall;
  logic             slot_valid [SLOTS];
  logic             shift_down;

  //////////////////////////////////////////////////
  // Stall and dispatch
  //////////////////////////////////////////////////

  // Slot 1 needs two free entries, slot 0 only one
  assign stall[0]   = full;
  assign stall[1]   = full | almost_full;
  assign in_ready   = ~|stall;
  assign shift_down = stall[1] & ~stall[0];   // Only slot 1 held back

  always_comb
  begin
    for (int s = 0; s < SLOTS; s++)
    begin
      dispatch_fire[s] = slot_valid[s] & ~stall[s];
    end
  end

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        slot_valid[s] <= 1'b0;
        slot_ir[s]    <= NOOP_INST;
      end
    end
    else if (flush)
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        slot_valid[s] <= 1'b0;
        slot_ir[s]    <= NOOP_INST;
      end
    end
    else if (in_ready)
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        slot_valid[s] <= in_valid[s];
        slot_ir[s]    <= in_ir[s];
      end
    end
    else if (shift_down)
    begin
      // Slot 0 left this cycle, slot 1 takes its place
      slot_valid[0] <= slot_valid[1];
      slot_ir[0]    <= slot_ir[1];
      slot_valid[1] <= 1'b0;
    end
  end

  // Payload fields follow the same load and shift rules
  always_ff @(posedge clock)
  begin
    if (in_ready)
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        slot_pdest[s] <= in_pdest[s];
        slot_prega[s] <= in_prega[s];
        slot_pregb[s] <= in_pregb[s];
        slot_npc[s]   <= in_npc[s];
      end
    end
    else if (shift_down)
    begin
      slot_pdest[0] <= slot_pdest[1];
      slot_prega[0] <= slot_prega[1];
      slot_pregb[0] <= slot_pregb[1];
      slot_npc[0]   <= slot_npc[1];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/operand_read.sv ====
// Operand read and issue register
`default_nettype none

module operand_read
  import ooo_pkg::*;
(
  input  wire              clock,
  input  wire              arst_n,
  input  wire              flush,

  // Dispatched pair
  input  wire              dispatch_fire [SLOTS],
  input  wire  preg_idx_t  slot_pdest    [SLOTS],
  input  wire  preg_idx_t  slot_prega    [SLOTS],
  input  wire  preg_idx_t  slot_pregb    [SLOTS],
  input  wire  inst_t      slot_ir       [SLOTS],
  input  wire  word_t      slot_npc      [SLOTS],

  // CDB
  input  wire              cdb_valid [SLOTS],
  input  wire  preg_idx_t  cdb_tag   [SLOTS],
  input  wire  word_t      cdb_value [SLOTS],

  // Register file, even ports for A and odd for B
  output preg_idx_t        rf_rd_idx  [OPND_PORTS],
  input  wire  word_t      rf_rd_data [OPND_PORTS],

  // Issue register
  output logic             issue_valid      [SLOTS],
  output preg_idx_t        issue_pdest      [SLOTS],
  output word_t            issue_rega_value [SLOTS],
  output word_t            issue_regb_value [SLOTS],
  output inst_t            issue_ir         [SLOTS],
  output word_t            issue_npc        [SLOTS]
);

  word_t opnd_value [OPND_PORTS];

  always_comb
  begin
    for (int s = 0; s < SLOTS; s++)
    begin
      rf_rd_idx[2*s]   = slot_prega[s];
      rf_rd_idx[2*s+1] = slot_pregb[s];
    end
  end

  //////////////////////////////////////////////////
  // Zero and CDB forwarding
  //////////////////////////////////////////////////

  // Later assignments win, so CDB slot 0 is checked last
  always_comb
  begin
    for (int p = 0; p < OPND_PORTS; p++)
    begin
      opnd_value[p] = rf_rd_data[p];
      for (int c = SLOTS - 1; c >= 0; c--)
      begin
        if (cdb_valid[c] && (cdb_tag[c] == rf_rd_idx[p]))
        begin
          opnd_value[p] = cdb_value[c];
        end
      end
      if (rf_rd_idx[p] == ZERO_PRF)
      begin
        opnd_value[p] = '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        issue_valid[s] <= 1'b0;
        issue_ir[s]    <= NOOP_INST;
      end
    end
    else
    begin
      for (int s = 0; s < SLOTS; s++)
      begin
        issue_valid[s] <= dispatch_fire[s] & ~flush;
        issue_ir[s]    <= flush ? NOOP_INST : slot_ir[s];
      end
    end
  end

  always_ff @(posedge clock)
  begin
    for (int s = 0; s < SLOTS; s++)
    begin
      issue_pdest[s]      <= slot_pdest[s];
      issue_rega_value[s] <= opnd_value[2*s];
      issue_regb_value[s] <= opnd_value[2*s+1];
      issue_npc[s]        <= slot_npc[s];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/retire_report.sv ====
// Retire report and commit outputs
`default_nettype none

module retire_report
  import ooo_pkg::*;
(
  // Retiring pair from the ROB
  input  wire              retire_valid [SLOTS],
  input  wire  preg_idx_t  retire_pdest [SLOTS],
  input  wire  areg_idx_t  retire_adest [SLOTS],
  input  wire  inst_t      retire_ir    [SLOTS],

  // Register file lookup of the retiring values
  output preg_idx_t        rf_rd_idx  [SLOTS],
  input  wire  word_t      rf_rd_data [SLOTS],

  output logic [COUNT_W-1:0] completed_insts,
  output err_status_t      error_status,
  output logic             commit_wr_en   [SLOTS],
  output areg_idx_t        commit_wr_idx  [SLOTS],
  output word_t            commit_wr_data [SLOTS]
);

  logic halt_seen;

  always_comb
  begin
    completed_insts = '0;
    halt_seen       = 1'b0;
    for (int s = 0; s < SLOTS; s++)
    begin
      rf_rd_idx[s]      = retire_pdest[s];
      completed_insts   = completed_insts + COUNT_W'(retire_valid[s]);
      halt_seen         = halt_seen | (retire_valid[s] && (retire_ir[s] == HALT_INST));
      // No architectural write for the zero register
      commit_wr_en[s]   = retire_valid[s] && (retire_pdest[s] != ZERO_PRF);
      commit_wr_idx[s]  = retire_adest[s];
      commit_wr_data[s] = rf_rd_data[s];
    end
  end

  assign error_status = halt_seen ? HALTED_ON_HALT : NO_ERROR;

endmodule

`default_nettype wire

// ==== verilog/ooo_backend_slice.sv ====
// Out-of-order back-end datapath slice
`default_nettype none

module ooo_backend_slice
  import ooo_pkg::*;
(
  input  wire              clock,
  input  wire              arst_n,
  input  wire              flush,
  input  wire              full,
  input  wire              almost_full,

  // Decode side
  input  wire              in_valid  [SLOTS],
  input  wire  preg_idx_t  in_pdest  [SLOTS],
  input  wire  preg_idx_t  in_prega  [SLOTS],
  input  wire  preg_idx_t  in_pregb  [SLOTS],
  input  wire  inst_t      in_ir     [SLOTS],
  input  wire  word_t      in_npc    [SLOTS],
  output logic             in_ready,
  output logic             dispatch_fire [SLOTS],

  // CDB
  input  wire              cdb_valid [SLOTS],
  input  wire  preg_idx_t  cdb_tag   [SLOTS],
  input  wire  word_t      cdb_value [SLOTS],

  // Issue
  output logic             issue_valid      [SLOTS],
  output preg_idx_t        issue_pdest      [SLOTS],
  output word_t            issue_rega_value [SLOTS],
  output word_t            issue_regb_value [SLOTS],
  output inst_t            issue_ir         [SLOTS],
  output word_t            issue_npc        [SLOTS],

  // Retire and commit
  input  wire              retire_valid [SLOTS],
  input  wire  preg_idx_t  retire_pdest [SLOTS],
  input  wire  areg_idx_t  retire_adest [SLOTS],
  input  wire  inst_t      retire_ir    [SLOTS],
  output logic [COUNT_W-1:0] completed_insts,
  output err_status_t      error_status,
  output logic             commit_wr_en   [SLOTS],
  output areg_idx_t        commit_wr_idx  [SLOTS],
  output word_t            commit_wr_data [SLOTS]
);

  // Dispatch buffer to operand read
  preg_idx_t slot_pdest [SLOTS];
  preg_idx_t slot_prega [SLOTS];
  preg_idx_t slot_pregb [SLOTS];
  inst_t     slot_ir    [SLOTS];
  word_t     slot_npc   [SLOTS];

  // Register file read ports, split by user
  preg_idx_t opnd_rd_idx  [OPND_PORTS];
  word_t     opnd_rd_data [OPND_PORTS];
  preg_idx_t ret_rd_idx   [SLOTS];
  word_t     ret_rd_data  [SLOTS];
  preg_idx_t rf_rd_idx    [RF_RD_PORTS];
  word_t     rf_rd_data   [RF_RD_PORTS];

  for (genvar p = 0; p < OPND_PORTS; p++)
  begin : g_opnd_port
    assign rf_rd_idx[p]    = opnd_rd_idx[p];
    assign opnd_rd_data[p] = rf_rd_data[p];
  end

  for (genvar s = 0; s < SLOTS; s++)
  begin : g_ret_port
    assign rf_rd_idx[OPND_PORTS+s] = ret_rd_idx[s];   // Retire ports after operands
    assign ret_rd_data[s]          = rf_rd_data[OPND_PORTS+s];
  end

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  phys_regfile prf0 (
    .clock   (clock),
    .arst_n  (arst_n),
    .wr_en   (cdb_valid),
    .wr_idx  (cdb_tag),
    .wr_data (cdb_value),
    .rd_idx  (rf_rd_idx),
    .rd_data (rf_rd_data)
  );

  dispatch_buffer dbuf0 (
    .clock         (clock),
    .arst_n        (arst_n),
    .flush         (flush),
    .full          (full),
    .almost_full   (almost_full),
    .in_valid      (in_valid),
    .in_pdest      (in_pdest),
    .in_prega      (in_prega),
    .in_pregb      (in_pregb),
    .in_ir         (in_ir),
    .in_npc        (in_npc),
    .in_ready      (in_ready),
    .slot_pdest    (slot_pdest),
    .slot_prega    (slot_prega),
    .slot_pregb    (slot_pregb),
    .slot_ir       (slot_ir),
    .slot_npc      (slot_npc),
    .dispatch_fire (dispatch_fire)
  );

  operand_read oprd0 (
    .clock            (clock),
    .arst_n           (arst_n),
    .flush            (flush),
    .dispatch_fire    (dispatch_fire),
    .slot_pdest       (slot_pdest),
    .slot_prega       (slot_prega),
    .slot_pregb       (slot_pregb),
    .slot_ir          (slot_ir),
    .slot_npc         (slot_npc),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .cdb_value        (cdb_value),
    .rf_rd_idx        (opnd_rd_idx),
    .rf_rd_data       (opnd_rd_data),
    .issue_valid      (issue_valid),
    .issue_pdest      (issue_pdest),
    .issue_rega_value (issue_rega_value),
    .issue_regb_value (issue_regb_value),
    .issue_ir         (issue_ir),
    .issue_npc        (issue_npc)
  );

  retire_report rret0 (
    .retire_valid    (retire_valid),
    .retire_pdest    (retire_pdest),
    .retire_adest    (retire_adest),
    .retire_ir       (retire_ir),
    .rf_rd_idx       (ret_rd_idx),
    .rf_rd_data      (ret_rd_data),
    .completed_insts (completed_insts),
    .error_status    (error_status),
    .commit_wr_en    (commit_wr_en),
    .commit_wr_idx   (commit_wr_idx),
    .commit_wr_data  (commit_wr_data)
  );

endmodule

`default_nettype wire

// ==== verif/ooo_slice_properties.sv ====
// Back-end slice bound assertions
`default_nettype none

module ooo_slice_properties
  import ooo_pkg::*;
(
  input wire clock,
  input wire arst_n,
  input wire flush,
  input wire full,
  input wire almost_full,
  input wire in_ready,
  input wire dispatch_fire [SLOTS],
  input wire issue_valid   [SLOTS],
  input wire retire_valid  [SLOTS],
  input wire commit_wr_en  [SLOTS]
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;   // Read by the testbench at the end

  //////////////////////////////////////////////////
  // Pipeline control
  //////////////////////////////////////////////////

  a_flush_clears_issue : assert property (@(posedge clock) disable iff (!arst_n)
    flush |=> (!issue_valid[0] && !issue_valid[1]))
  else
  begin
    fail_count++;
    $error("issue_valid set in the cycle after a flush");
  end

  a_no_fire_when_full : assert property (@(posedge clock) disable iff (!arst_n)
    full |-> (!dispatch_fire[0] && !dispatch_fire[1]))
  else
  begin
    fail_count++;
    $error("dispatch_fire set while full");
  end

  a_not_ready_almost_full : assert property (@(posedge clock) disable iff (!arst_n)
    almost_full |-> !in_ready)
  else
  begin
    fail_count++;
    $error("in_ready set while almost_full");
  end

  //////////////////////////////////////////////////
  // Commit
  //////////////////////////////////////////////////

  for (genvar s = 0; s < SLOTS; s++)
  begin : g_commit
    a_commit_needs_retire : assert property (@(posedge clock) disable iff (!arst_n)
      commit_wr_en[s] |-> retire_valid[s])
    else
    begin
      fail_count++;
      $error("commit_wr_en set without retire_valid");
    end
  end

endmodule

bind ooo_backend_slice ooo_slice_properties props0 (
  .clock         (clock),
  .arst_n        (arst_n),
  .flush         (flush),
  .full          (full),
  .almost_full   (almost_full),
  .in_ready      (in_ready),
  .dispatch_fire (dispatch_fire),
  .issue_valid   (issue_valid),
  .retire_valid  (retire_valid),
  .commit_wr_en  (commit_wr_en)
);

`default_nettype wire

// ==== verif/tb_ooo_slice.sv ====
// Back-end slice testbench
`default_nettype none

module tb_ooo_slice
  import ooo_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 600;   // About ten times what the tests need
  localparam int ISSUE_WAIT     = 10;
  localparam int STALL_CYCLES   = 3;
  localparam int FLUSH_WATCH    = 4;
  localparam int RETIRE_CASES   = 12;

  logic clock;
  logic arst_n;
  logic flush;
  logic full;
  logic almost_full;

  logic      in_valid  [SLOTS];
  preg_idx_t in_pdest  [SLOTS];
  preg_idx_t in_prega  [SLOTS];
  preg_idx_t in_pregb  [SLOTS];
  inst_t     in_ir     [SLOTS];
  word_t     in_npc    [SLOTS];
  logic      in_ready;
  logic      dispatch_fire [SLOTS];

  logic      cdb_valid [SLOTS];
  preg_idx_t cdb_tag   [SLOTS];
  word_t     cdb_value [SLOTS];

  logic      issue_valid      [SLOTS];
  preg_idx_t issue_pdest      [SLOTS];
  word_t     issue_rega_value [SLOTS];
  word_t     issue_regb_value [SLOTS];
  inst_t     issue_ir         [SLOTS];
  word_t     issue_npc        [SLOTS];

  logic               retire_valid [SLOTS];
  preg_idx_t          retire_pdest [SLOTS];
  areg_idx_t          retire_adest [SLOTS];
  inst_t              retire_ir    [SLOTS];
  logic [COUNT_W-1:0] completed_insts;
  err_status_t        error_status;
  logic               commit_wr_en   [SLOTS];
  areg_idx_t          commit_wr_idx  [SLOTS];
  word_t              commit_wr_data [SLOTS];

  // Reference state kept by the testbench
  word_t       model_regs [PRF_SZ];
  preg_idx_t   sent_pdest [SLOTS];
  preg_idx_t   sent_prega [SLOTS];
  preg_idx_t   sent_pregb [SLOTS];
  inst_t       sent_ir    [SLOTS];
  word_t       sent_npc   [SLOTS];
  word_t       exp_a      [SLOTS];
  word_t       exp_b      [SLOTS];
  logic [31:0] rng_state = 32'h59c2_f61a;
  int          err_count   = 0;
  int          check_count = 0;
  int          tests_run   = 0;
  int          cycle_count = 0;

  ooo_backend_slice dut0 (.*);

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function word_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    $display("%-16s %s, %0d errors", name,
             (err_count == errs_at_start) ? "passed" : "failed", err_count - errs_at_start);
  endtask

  task automatic idle_inputs();
    flush       = 1'b0;
    full        = 1'b0;
    almost_full = 1'b0;
    for (int s = 0; s < SLOTS; s++)
    begin
      in_valid[s]     = 1'b0;
      in_pdest[s]     = '0;
      in_prega[s]     = '0;
      in_pregb[s]     = '0;
      in_ir[s]        = NOOP_INST;
      in_npc[s]       = '0;
      cdb_valid[s]    = 1'b0;
      cdb_tag[s]      = '0;
      cdb_value[s]    = '0;
      retire_valid[s] = 1'b0;
      retire_pdest[s] = '0;
      retire_adest[s] = '0;
      retire_ir[s]    = NOOP_INST;
    end
  endtask

  // CDB drive in the current cycle, model updated after the edge
  task automatic drive_cdb(input preg_idx_t t0, input word_t v0,
                           input preg_idx_t t1, input word_t v1);
    cdb_valid[0] = 1'b1;
    cdb_tag[0]   = t0;
    cdb_value[0] = v0;
    cdb_valid[1] = 1'b1;
    cdb_tag[1]   = t1;
    cdb_value[1] = v1;
  endtask

  task automatic release_cdb();
    for (int c = 0; c < SLOTS; c++)
    begin
      if (cdb_valid[c] && (cdb_tag[c] != ZERO_PRF))
      begin
        model_regs[cdb_tag[c]] = cdb_value[c];
      end
      cdb_valid[c] = 1'b0;
    end
  endtask

  task automatic write_regs(input preg_idx_t t0, input word_t v0,
                            input preg_idx_t t1, input word_t v1);
    drive_cdb(t0, v0, t1, v1);
    @(negedge clock);
    release_cdb();
  endtask

  // Zero first, then CDB slot 0, then CDB slot 1, then the register
  function automatic word_t operand_expect(input preg_idx_t idx);
    if (idx == ZERO_PRF)
    begin
      return '0;
    end
    for (int c = 0; c < SLOTS; c++)
    begin
      if (cdb_valid[c] && (cdb_tag[c] == idx))
      begin
        return cdb_value[c];
      end
    end
    return model_regs[idx];
  endfunction

  task automatic capture_expect();
    for (int s = 0; s < SLOTS; s++)
    begin
      exp_a[s] = operand_expect(sent_prega[s]);
      exp_b[s] = operand_expect(sent_pregb[s]);
    end
  endtask

  // Offers a pair, returns in its dispatch cycle
  task automatic send_pair(input preg_idx_t d0, input preg_idx_t a0, input preg_idx_t b0,
                           input preg_idx_t d1, input preg_idx_t a1, input preg_idx_t b1);
    sent_pdest[0] = d0;
    sent_prega[0] = a0;
    sent_pregb[0] = b0;
    sent_pdest[1] = d1;
    sent_prega[1] = a1;
    sent_pregb[1] = b1;
    for (int s = 0; s < SLOTS; s++)
    begin
      sent_ir[s]  = rand32();
      sent_npc[s] = rand_word();
      in_valid[s] = 1'b1;
      in_pdest[s] = sent_pdest[s];
      in_prega[s] = sent_prega[s];
      in_pregb[s] = sent_pregb[s];
      in_ir[s]    = sent_ir[s];
      in_npc[s]   = sent_npc[s];
    end
    @(negedge clock);
    in_valid[0] = 1'b0;
    in_valid[1] = 1'b0;
  endtask

  // A pair that must never be taken while stalled
  task automatic offer_decoy();
    for (int s = 0; s < SLOTS; s++)
    begin
      in_valid[s] = 1'b1;
      in_pdest[s] = preg_idx_t'(rand32());
      in_prega[s] = preg_idx_t'(rand32());
      in_pregb[s] = preg_idx_t'(rand32());
      in_ir[s]    = rand32();
      in_npc[s]   = rand_word();
    end
  endtask

  task automatic check_issue(input int s, input int src);
    check_value($sformatf("issue_valid[%0d]", s), issue_valid[s], 1'b1);
    check_value($sformatf("issue_pdest[%0d]", s), issue_pdest[s], sent_pdest[src]);
    check_value($sformatf("issue_rega_value[%0d]", s), issue_rega_value[s], exp_a[src]);
    check_value($sformatf("issue_regb_value[%0d]", s), issue_regb_value[s], exp_b[src]);
    check_value($sformatf("issue_ir[%0d]", s), issue_ir[s], sent_ir[src]);
    check_value($sformatf("issue_npc[%0d]", s), issue_npc[s], sent_npc[src]);
  endtask

  task automatic wait_issue(input string what);
    int waited;
    waited = 0;
    do
    begin
      @(negedge clock);
      waited++;
    end
    while (!issue_valid[0] && (waited < ISSUE_WAIT));
    if (!issue_valid[0])
    begin
      err_count++;
      $display("%s: nothing issued within %0d cycles", what, ISSUE_WAIT);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    int errs_at_start;
    errs_at_start = err_count;
    check_value("in_ready", in_ready, 1'b1);
    for (int s = 0; s < SLOTS; s++)
    begin
      check_value("dispatch_fire", dispatch_fire[s], 1'b0);
      check_value("issue_valid", issue_valid[s], 1'b0);
      check_value("issue_ir", issue_ir[s], NOOP_INST);
    end
    report_test("reset state", errs_at_start);
  endtask

  task automatic test_basic_issue();
    int errs_at_start;
    errs_at_start = err_count;
    write_regs(6'd1, rand_word(), 6'd2, rand_word());
    write_regs(6'd3, rand_word(), 6'd4, rand_word());
    send_pair(6'd10, 6'd1, 6'd2, 6'd11, 6'd3, 6'd4);
    capture_expect();
    check_value("dispatch_fire[0]", dispatch_fire[0], 1'b1);
    check_value("dispatch_fire[1]", dispatch_fire[1], 1'b1);
    @(negedge clock);
    check_issue(0, 0);
    check_issue(1, 1);
    report_test("basic issue", errs_at_start);
  endtask

  task automatic test_forwarding();
    int errs_at_start;
    errs_at_start = err_count;
    write_regs(6'd20, rand_word(), 6'd5, rand_word());
    send_pair(6'd12, 6'd20, 6'd21, 6'd13, 6'd20, 6'd5);
    drive_cdb(6'd20, rand_word(), 6'd21, rand_word());   // Results land in dispatch cycle
    capture_expect();
    @(negedge clock);
    release_cdb();
    check_issue(0, 0);
    check_issue(1, 1);
    report_test("forwarding", errs_at_start);
  endtask

  task automatic test_zero_register();
    int errs_at_start;
    errs_at_start = err_count;
    send_pair(6'd14, ZERO_PRF, ZERO_PRF, 6'd15, ZERO_PRF, 6'd1);
    drive_cdb(ZERO_PRF, rand_word(), 6'd1, rand_word());
    capture_expect();
    @(negedge clock);
    release_cdb();
    check_issue(0, 0);
    check_issue(1, 1);
    report_test("zero register", errs_at_start);
  endtask

  task automatic test_full_stall();
    int errs_at_start;
    errs_at_start = err_count;
    send_pair(6'd16, 6'd1, 6'd2, 6'd17, 6'd3, 6'd4);
    full = 1'b1;
    offer_decoy();
    #1;
    check_value("in_ready under full", in_ready, 1'b0);
    check_value("dispatch_fire[0] under full", dispatch_fire[0], 1'b0);
    check_value("dispatch_fire[1] under full", dispatch_fire[1], 1'b0);
    repeat (STALL_CYCLES)
    begin
      @(negedge clock);
      check_value("issue_valid[0] under full", issue_valid[0], 1'b0);
      check_value("issue_valid[1] under full", issue_valid[1], 1'b0);
      check_value("in_ready under full", in_ready, 1'b0);
    end
    full        = 1'b0;
    in_valid[0] = 1'b0;
    in_valid[1] = 1'b0;
    capture_expect();
    wait_issue("full release");
    check_issue(0, 0);
    check_issue(1, 1);
    report_test("full stall", errs_at_start);
  endtask

  task automatic test_almost_full();
    int errs_at_start;
    errs_at_start = err_count;
    send_pair(6'd18, 6'd1, 6'd3, 6'd19, 6'd2, 6'd4);
    almost_full = 1'b1;
    #1;
    check_value("in_ready under almost_full", in_ready, 1'b0);
    check_value("dispatch_fire[0] under almost_full", dispatch_fire[0], 1'b1);
    check_value("dispatch_fire[1] under almost_full", dispatch_fire[1], 1'b0);
    capture_expect();
    @(negedge clock);
    check_issue(0, 0);
    check_value("issue_valid[1] under almost_full", issue_valid[1], 1'b0);
    almost_full = 1'b0;
    // Slot 1 now sits in slot 0
    wait_issue("almost_full release");
    check_issue(0, 1);
    check_value("issue_valid[1] after shift", issue_valid[1], 1'b0);
    report_test("almost full", errs_at_start);
  endtask

  task automatic test_flush();
    int errs_at_start;
    errs_at_start = err_count;
    send_pair(6'd22, 6'd1, 6'd2, 6'd23, 6'd3, 6'd4);
    full = 1'b1;                         // Keep the pair in the buffer
    @(negedge clock);
    full  = 1'b0;
    flush = 1'b1;                        // Pair would dispatch in this cycle
    #1;
    check_value("dispatch_fire[0] with flush", dispatch_fire[0], 1'b1);
    @(negedge clock);
    check_value("issue_valid[0] after flush", issue_valid[0], 1'b0);
    check_value("issue_valid[1] after flush", issue_valid[1], 1'b0);
    check_value("issue_ir[0] after flush", issue_ir[0], NOOP_INST);
    flush = 1'b0;
    #1;
    check_value("dispatch_fire[0] after flush", dispatch_fire[0], 1'b0);
    check_value("dispatch_fire[1] after flush", dispatch_fire[1], 1'b0);
    repeat (FLUSH_WATCH)
    begin
      @(negedge clock);
      check_value("issue_valid[0] after flush", issue_valid[0], 1'b0);
      check_value("issue_valid[1] after flush", issue_valid[1], 1'b0);
    end
    report_test("flush", errs_at_start);
  endtask

  task automatic test_retire();
    int          errs_at_start;
    logic [31:0] r;
    int          exp_count;
    logic        exp_halt;
    errs_at_start = err_count;
    for (int i = 0; i < RETIRE_CASES; i++)
    begin
      r = rand32();
      for (int s = 0; s < SLOTS; s++)
      begin
        retire_valid[s] = r[s];
        retire_pdest[s] = preg_idx_t'(rand32());
        retire_adest[s] = areg_idx_t'(rand32());
        retire_ir[s]    = r[2+s] ? HALT_INST : inst_t'(rand32());
      end
      if (i == 0)
      begin
        // Zero destination and a halt, both retiring
        retire_valid[0] = 1'b1;
        retire_valid[1] = 1'b1;
        retire_pdest[0] = ZERO_PRF;
        retire_ir[1]    = HALT_INST;
      end
      else if (i == 1)
      begin
        retire_valid[0] = 1'b1;   // Halt only on a slot that is not retiring
        retire_pdest[0] = 6'd1;   // A register the CDB wrote
        retire_ir[0]    = NOOP_INST;
        retire_valid[1] = 1'b0;
        retire_ir[1]    = HALT_INST;
      end
      #1;
      exp_count = 0;
      exp_halt  = 1'b0;
      for (int s = 0; s < SLOTS; s++)
      begin
        if (retire_valid[s])
        begin
          exp_count++;
          exp_halt = exp_halt | (retire_ir[s] == HALT_INST);
        end
        check_value("commit_wr_en", commit_wr_en[s],
                    retire_valid[s] && (retire_pdest[s] != ZERO_PRF));
        check_value("commit_wr_idx", commit_wr_idx[s], retire_adest[s]);
        check_value("commit_wr_data", commit_wr_data[s], model_regs[retire_pdest[s]]);
      end
      check_value("completed_insts", completed_insts, exp_count);
      check_value("error_status", error_status, exp_halt ? HALTED_ON_HALT : NO_ERROR);
      @(negedge clock);
    end
    retire_valid[0] = 1'b0;
    retire_valid[1] = 1'b0;
    report_test("retire", errs_at_start);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int total_errors;
    arst_n = 1'b0;
    idle_inputs();
    for (int r = 0; r < PRF_SZ; r++)
    begin
      model_regs[r] = '0;
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;

    test_reset_state();
    test_basic_issue();
    test_forwarding();
    test_zero_register();
    test_full_stall();
    test_almost_full();
    test_flush();
    test_retire();

    total_errors = err_count + dut0.props0.fail_count;
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count,
             total_errors);
    if (total_errors == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/ooo_pkg.sv
verilog/phys_regfile.sv
verilog/dispatch_buffer.sv
verilog/operand_read.sv
verilog/retire_report.sv
verilog/ooo_backend_slice.sv
verif/ooo_slice_properties.sv
verif/tb_ooo_slice.sv
